//--- flist.f
rtl/rvPkg.sv
rtl/registerFile.sv
rtl/instructionDecoder.sv
rtl/aluUnit.sv
rtl/nextPcUnit.sv
rtl/cpuCore.sv
verification/clockGen.sv
verification/cpuCore_checker.sv
verification/cpuCoreTb.sv

//--- Makefile
TOP = cpuCoreTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timescale 1ns/100ps --top-module $(TOP) \
		-f flist.f -Mdir obj_dir -o simv

run: compile
	@out=$$(./obj_dir/simv 2>&1); echo "$$out"; \
		echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

//--- verification/cpuCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

module cpuCoreTb;

    import rvPkg::*;

    localparam int numCycles = 3000;
    localparam int clkPeriod = 40;

    logic clk;
    logic reset;
    logic [31:0] iaddr;
    logic [31:0] idata;
    logic [31:0] daddr;
    logic [31:0] drdata;
    logic [31:0] dwdata;
    logic [3:0] dwe;

    logic [31:0] prog [256];
    logic [31:0] dmem [256];
    logic [31:0] mRegs [32];
    logic [31:0] mPc;

    clockGen clockGen_i (
        .clk(clk),
        .reset(reset)
    );

    cpuCore cpuCore_i (
        .clk(clk),
        .reset(reset),
        .iaddr(iaddr),
        .idata(idata),
        .daddr(daddr),
        .drdata(drdata),
        .dwdata(dwdata),
        .dwe(dwe)
    );

    // combinational memories
    assign idata = prog[iaddr[9:2]];
    assign drdata = dmem[daddr[9:2]];

    always @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (dwe[i]) begin
                dmem[daddr[9:2]][8*i +: 8] <= dwdata[8*i +: 8];
            end
        end
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            $display("Test failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    function automatic logic [31:0] randomInstr();
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [31:0] r;
        logic [31:0] step;
        logic [12:0] bOff;
        logic [20:0] jOff;
        logic [11:0] off;
        rd = 5'($urandom_range(0, 7));
        rs1 = 5'($urandom_range(0, 7));
        rs2 = 5'($urandom_range(0, 7));
        f3 = 3'($urandom_range(0, 7));
        r = $urandom;
        step = $urandom_range(1, 12);
        // small forward offsets
        bOff = 13'(step * 4);
        jOff = 21'(step * 4);
        // mostly aligned word offsets
        off = {2'b00, r[15:8], (r[2:0] == 3'd0) ? r[4:3] : 2'b00};
        f7 = (r[0] && (f3 == 3'd0 || f3 == 3'd5)) ? funct7Alt : 7'h00;
        if (r[7:4] == 4'hf) begin
            f7 = r[22:16];
        end
        case ($urandom_range(0, 12))
            0, 1: return {f7, rs2, rs1, f3, rd, opAlu};
            2, 3: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    return {f7, r[28:24], rs1, f3, rd, opAluImm};
                end
                return {r[31:20], rs1, f3, rd, opAluImm};
            end
            4: return {r[31:12], rd, opLui};
            5: return {r[31:12], rd, opAuipc};
            6: return {jOff[20], jOff[10:1], jOff[11], jOff[19:12], rd, opJal};
            7: return {bOff[11:0], rs1, (r[3:0] == 4'h0) ? f3 : 3'b000, rd, opJalr};
            8: return {bOff[12], bOff[10:5], rs2, rs1, f3, bOff[4:1], bOff[11], opBranch};
            9: return {off, 5'd0, f3Word, rd, opLoad};
            10, 11: return {off[11:5], rs2, 5'd0, f3Word, off[4:0], opStore};
            default: return {r[31:7], 7'b0001011};
        endcase
    endfunction

    function automatic logic [31:0] arithResult(input logic [2:0] f3, input logic alt,
                                                input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // one instruction of the reference model checked against the DUT
    task automatic stepModel();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immJ;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] nextPc;
        logic [6:0] f7;
        logic [2:0] f3;
        logic [3:0] expDwe;
        logic wr;
        logic taken;
        ins = prog[mPc[9:2]];
        f3 = ins[14:12];
        f7 = ins[31:25];
        a = mRegs[ins[19:15]];
        b = mRegs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nextPc = mPc + 32'd4;
        wr = 1'b0;
        res = '0;
        expDwe = 4'b0000;
        case (ins[6:0])
            opAlu: begin
                wr = (f7 == 7'h00) || (f7 == funct7Alt && (f3 == 3'd0 || f3 == 3'd5));
                res = arithResult(f3, f7 == funct7Alt, a, b);
            end
            opAluImm: begin
                wr = (f3 == 3'd1) ? f7 == 7'h00 :
                     (f3 == 3'd5) ? (f7 == 7'h00 || f7 == funct7Alt) : 1'b1;
                res = arithResult(f3, f3 == 3'd5 && f7 == funct7Alt, a, immI);
            end
            opLoad: begin
                addr = a + immI;
                wr = (f3 == 3'd2);
                res = dmem[addr[9:2]];
            end
            opStore: begin
                addr = a + immS;
                if (f3 == 3'd2 && addr[1:0] == 2'b00) begin
                    expDwe = 4'b1111;
                    checkValue("daddr", daddr, addr);
                    checkValue("dwdata", dwdata, b);
                end
            end
            opLui: begin
                wr = 1'b1;
                res = {ins[31:12], 12'b0};
            end
            opAuipc: begin
                wr = 1'b1;
                res = mPc + {ins[31:12], 12'b0};
            end
            opJal: begin
                wr = 1'b1;
                res = mPc + 32'd4;
                nextPc = mPc + immJ;
            end
            opJalr: begin
                if (f3 == 3'd0) begin
                    wr = 1'b1;
                    res = mPc + 32'd4;
                    nextPc = (a + immI) & ~32'h1;
                end
            end
            opBranch: begin
                case (f3)
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = $signed(a) < $signed(b);
                    3'd5: taken = $signed(a) >= $signed(b);
                    3'd6: taken = a < b;
                    3'd7: taken = a >= b;
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    nextPc = mPc + immB;
                end
            end
            default: begin
                wr = 1'b0;
            end
        endcase
        checkValue("dwe", {28'b0, dwe}, {28'b0, expDwe});
        if (wr && ins[11:7] != 5'd0) begin
            mRegs[ins[11:7]] = res;
        end
        mPc = nextPc;
    endtask

    initial begin
        #((numCycles + 20) * clkPeriod);
        $display("timeout: the run did not complete in the expected time");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(99));
        for (int i = 0; i < 256; i++) begin
            prog[i] = randomInstr();
            dmem[i] <= $urandom;
        end
        // an aligned store at address 0 makes the reset gating of dwe visible
        prog[0] = {7'd0, 5'd0, 5'd0, f3Word, 5'd0, opStore};
        for (int i = 0; i < 32; i++) begin
            mRegs[i] = '0;
        end
        mPc = '0;
        @(negedge clk);
        while (reset) begin
            checkValue("dwe", {28'b0, dwe}, 32'h0);
            checkValue("iaddr", iaddr, 32'h0);
            @(negedge clk);
        end
        // lockstep with the model at the falling edge
        for (int c = 0; c < numCycles; c++) begin
            checkValue("iaddr", iaddr, mPc);
            stepModel();
            @(negedge clk);
        end
        if (cpuCore_i.cpuCore_checker_i.failCount == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "assertion failures on the memory port");
        end
    end

endmodule

`default_nettype wire

//--- verification/cpuCore_checker.sv
`timescale 1ns/100ps
`default_nettype none

module cpuCore_checker (
    input wire logic                   clk,
    input wire logic                   reset,
    input wire logic [rvPkg::xlen-1:0] iaddr,
    input wire logic [rvPkg::xlen-1:0] daddr,
    input wire logic [3:0]             dwe
);

    import rvPkg::*;

    int failCount = 0;

    dweInReset: assert property (@(posedge clk) reset |-> dwe == 4'b0000)
        else begin
            $error("store strobe active while reset is high");
            failCount++;
        end

    // only full word stores exist
    dweLanes: assert property (@(posedge clk) dwe == 4'b0000 || dwe == storeAllLanes)
        else begin
            $error("store strobe is neither zero nor all lanes");
            failCount++;
        end

    dweAligned: assert property (@(posedge clk) dwe != 4'b0000 |-> daddr[1:0] == 2'b00)
        else begin
            $error("store issued to a misaligned address");
            failCount++;
        end

    pcAfterReset: assert property (@(posedge clk) $fell(reset) |-> iaddr[1:0] == 2'b00)
        else begin
            $error("instruction address not word aligned after reset");
            failCount++;
        end

endmodule

bind cpuCore cpuCore_checker cpuCore_checker_i (
    .clk(clk),
    .reset(reset),
    .iaddr(iaddr),
    .daddr(daddr),
    .dwe(dwe)
);

`default_nettype wire

//--- verification/clockGen.sv
`timescale 1ns/100ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic reset
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held for two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- rtl/cpuCore.sv
`timescale 1ns/100ps
`default_nettype none

module cpuCore (
    input  wire logic                   clk,
    input  wire logic                   reset,
    output logic      [rvPkg::xlen-1:0] iaddr,
    input  wire logic [rvPkg::xlen-1:0] idata,
    output logic      [rvPkg::xlen-1:0] daddr,
    input  wire logic [rvPkg::xlen-1:0] drdata,
    output logic      [rvPkg::xlen-1:0] dwdata,
    output logic      [3:0]             dwe
);

    import rvPkg::*;

    logic [regAddrWidth-1:0] rs1;
    logic [regAddrWidth-1:0] rs2;
    logic [regAddrWidth-1:0] rd;
    logic regWrite;
    logic [xlen-1:0] writeBack;
    logic [xlen-1:0] rv1;
    logic [xlen-1:0] rv2;
    aluOp op;
    logic useImm;
    logic [xlen-1:0] imm;
    logic [2:0] funct3;
    logic isJal;
    logic isJalr;
    logic isBranch;

    registerFile registerFile_i (
        .clk(clk),
        .reset(reset),
        .readAddr1(rs1),
        .readAddr2(rs2),
        .writeAddr(rd),
        .writeEnable(regWrite),
        .writeData(writeBack),
        .readData1(rv1),
        .readData2(rv2)
    );

    // the alu result doubles as the data address
    instructionDecoder instructionDecoder_i (
        .reset(reset),
        .instruction(idata),
        .loadData(drdata),
        .aluResult(daddr),
        .rs1(rs1),
        .rs2(rs2),
        .rd(rd),
        .regWrite(regWrite),
        .writeBack(writeBack),
        .op(op),
        .useImm(useImm),
        .imm(imm),
        .funct3(funct3),
        .isJal(isJal),
        .isJalr(isJalr),
        .isBranch(isBranch),
        .dwe(dwe)
    );

    aluUnit aluUnit_i (
        .op(op),
        .a(rv1),
        .b(rv2),
        .imm(imm),
        .pc(iaddr),
        .useImm(useImm),
        .result(daddr)
    );

    nextPcUnit nextPcUnit_i (
        .clk(clk),
        .reset(reset),
        .rv1(rv1),
        .rv2(rv2),
        .imm(imm),
        .funct3(funct3),
        .isJal(isJal),
        .isJalr(isJalr),
        .isBranch(isBranch),
        .pc(iaddr)
    );

    assign dwdata = rv2;

endmodule

`default_nettype wire

//--- rtl/nextPcUnit.sv
`timescale 1ns/100ps
`default_nettype none

module nextPcUnit (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic [rvPkg::xlen-1:0] rv1,
    input  wire logic [rvPkg::xlen-1:0] rv2,
    input  wire logic [rvPkg::xlen-1:0] imm,
    input  wire logic [2:0]             funct3,
    input  wire logic                   isJal,
    input  wire logic                   isJalr,
    input  wire logic                   isBranch,
    output logic      [rvPkg::xlen-1:0] pc
);

    import rvPkg::*;

    logic taken;
    logic [xlen-1:0] jumpSum;
    logic [xlen-1:0] nextPc;

    // unused funct3 values never branch
    always_comb begin
        case (funct3)
            f3Beq: taken = (rv1 == rv2);
            f3Bne: taken = (rv1 != rv2);
            f3Blt: taken = ($signed(rv1) < $signed(rv2));
            f3Bge: taken = ($signed(rv1) >= $signed(rv2));
            f3Bltu: taken = (rv1 < rv2);
            f3Bgeu: taken = (rv1 >= rv2);
            default: taken = 1'b0;
        endcase
    end

    assign jumpSum = rv1 + imm;

    always_comb begin
        if (isJalr) begin
            nextPc = {jumpSum[xlen-1:1], 1'b0};
        end else if (isJal || (isBranch && taken)) begin
            nextPc = pc + imm;
        end else begin
            nextPc = pc + instrStep;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

//--- rtl/aluUnit.sv
`timescale 1ns/100ps
`default_nettype none

module aluUnit (
    input  wire rvPkg::aluOp            op,
    input  wire logic [rvPkg::xlen-1:0] a,
    input  wire logic [rvPkg::xlen-1:0] b,
    input  wire logic [rvPkg::xlen-1:0] imm,
    input  wire logic [rvPkg::xlen-1:0] pc,
    input  wire logic                   useImm,
    output logic      [rvPkg::xlen-1:0] result
);

    import rvPkg::*;

    logic [xlen-1:0] operandB;
    logic [4:0] shamt;
    logic [xlen-1:0] pcOffset;

    assign operandB = useImm ? imm : b;
    assign shamt = operandB[4:0];
    // auipc adds the immediate and a link adds the step
    assign pcOffset = useImm ? imm : instrStep;

    always_comb begin
        case (op)
            aluAdd: result = a + operandB;
            aluSub: result = a - operandB;
            aluSll: result = a << shamt;
            aluSlt: result = {{(xlen-1){1'b0}}, $signed(a) < $signed(operandB)};
            aluSltu: result = {{(xlen-1){1'b0}}, a < operandB};
            aluXor: result = a ^ operandB;
            aluSrl: result = a >> shamt;
            aluSra: result = $unsigned($signed(a) >>> shamt);
            aluOr: result = a | operandB;
            aluAnd: result = a & operandB;
            aluPassImm: result = imm;
            aluAddPc: result = pc + pcOffset;
            aluAddAddr: result = a + imm;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/instructionDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module instructionDecoder (
    input  wire logic                           reset,
    input  wire logic [rvPkg::xlen-1:0]         instruction,
    input  wire logic [rvPkg::xlen-1:0]         loadData,
    input  wire logic [rvPkg::xlen-1:0]         aluResult,
    output logic      [rvPkg::regAddrWidth-1:0] rs1,
    output logic      [rvPkg::regAddrWidth-1:0] rs2,
    output logic      [rvPkg::regAddrWidth-1:0] rd,
    output logic                                regWrite,
    output logic      [rvPkg::xlen-1:0]         writeBack,
    output rvPkg::aluOp                         op,
    output logic                                useImm,
    output logic      [rvPkg::xlen-1:0]         imm,
    output logic      [2:0]                     funct3,
    output logic                                isJal,
    output logic                                isJalr,
    output logic                                isBranch,
    output logic      [3:0]                     dwe
);

    import rvPkg::*;

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [xlen-1:0] immI;
    logic [xlen-1:0] immS;
    logic [xlen-1:0] immB;
    logic [xlen-1:0] immU;
    logic [xlen-1:0] immJ;
    logic writeEnable;
    logic isLoad;
    logic [3:0] storeStrobe;
    logic altSel;

    function automatic aluOp arithOp(input logic [2:0] f3, input logic alt);
        case (f3)
            f3Add: arithOp = alt ? aluSub : aluAdd;
            f3Sll: arithOp = aluSll;
            f3Slt: arithOp = aluSlt;
            f3Sltu: arithOp = aluSltu;
            f3Xor: arithOp = aluXor;
            f3Srl: arithOp = alt ? aluSra : aluSrl;
            f3Or: arithOp = aluOr;
            default: arithOp = aluAnd;
        endcase
    endfunction

    assign opcode = instruction[6:0];
    assign rd = instruction[11:7];
    assign funct3 = instruction[14:12];
    assign rs1 = instruction[19:15];
    assign rs2 = instruction[24:20];
    assign funct7 = instruction[31:25];
    assign altSel = (funct7 == funct7Alt);

    assign immI = {{20{instruction[31]}}, instruction[31:20]};
    assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immB = {{19{instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};
    assign immU = {instruction[31:12], 12'b0};
    assign immJ = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                   instruction[20], instruction[30:21], 1'b0};

    always_comb begin
        writeEnable = 1'b0;
        storeStrobe = '0;
        isLoad = 1'b0;
        op = aluAdd;
        useImm = 1'b0;
        imm = '0;
        isJal = 1'b0;
        isJalr = 1'b0;
        isBranch = 1'b0;
        case (opcode)
            opAlu: begin
                op = arithOp(funct3, altSel);
                // alternate encoding only exists for sub and sra
                writeEnable = (funct7 == '0) ||
                              (altSel && (funct3 == f3Add || funct3 == f3Srl));
            end
            opAluImm: begin
                op = arithOp(funct3, altSel && funct3 == f3Srl);
                useImm = 1'b1;
                imm = immI;
                if (funct3 == f3Sll) begin
                    writeEnable = (funct7 == '0);
                end else if (funct3 == f3Srl) begin
                    writeEnable = (funct7 == '0) || altSel;
                end else begin
                    writeEnable = 1'b1;
                end
            end
            opLoad: begin
                op = aluAddAddr;
                imm = immI;
                isLoad = 1'b1;
                writeEnable = (funct3 == f3Word);
            end
            opStore: begin
                op = aluAddAddr;
                imm = immS;
                // misaligned word stores are dropped
                if (funct3 == f3Word && aluResult[1:0] == 2'b00) begin
                    storeStrobe = storeAllLanes;
                end
            end
            opLui: begin
                op = aluPassImm;
                imm = immU;
                writeEnable = 1'b1;
            end
            opAuipc: begin
                op = aluAddPc;
                useImm = 1'b1;
                imm = immU;
                writeEnable = 1'b1;
            end
            opJal: begin
                // link is pc plus step, so useImm stays low
                op = aluAddPc;
                imm = immJ;
                isJal = 1'b1;
                writeEnable = 1'b1;
            end
            opJalr: begin
                op = aluAddPc;
                imm = immI;
                isJalr = (funct3 == 3'b000);
                writeEnable = (funct3 == 3'b000);
            end
            opBranch: begin
                imm = immB;
                isBranch = 1'b1;
            end
            default: begin
                writeEnable = 1'b0;
            end
        endcase
    end

    assign writeBack = isLoad ? loadData : aluResult;
    assign regWrite = writeEnable && !reset;
    assign dwe = reset ? 4'b0000 : storeStrobe;

endmodule

`default_nettype wire

//--- rtl/registerFile.sv
`timescale 1ns/100ps
`default_nettype none

module registerFile (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic [rvPkg::regAddrWidth-1:0] readAddr1,
    input  wire logic [rvPkg::regAddrWidth-1:0] readAddr2,
    input  wire logic [rvPkg::regAddrWidth-1:0] writeAddr,
    input  wire logic                           writeEnable,
    input  wire logic [rvPkg::xlen-1:0]         writeData,
    output logic      [rvPkg::xlen-1:0]         readData1,
    output logic      [rvPkg::xlen-1:0]         readData2
);

    import rvPkg::*;

    logic [xlen-1:0] regs [numRegs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // x0 is hardwired to zero
    assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
    assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

`default_nettype wire

//--- rtl/rvPkg.sv
`default_nettype none

package rvPkg;

    localparam int xlen = 32;
    localparam int regAddrWidth = 5;
    localparam int numRegs = 32;

    // major opcodes of the supported classes
    localparam logic [6:0] opLoad = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opAlu = 7'b0110011;
    localparam logic [6:0] opAluImm = 7'b0010011;
    localparam logic [6:0] opLui = 7'b0110111;
    localparam logic [6:0] opAuipc = 7'b0010111;
    localparam logic [6:0] opJal = 7'b1101111;
    localparam logic [6:0] opJalr = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;

    localparam logic [2:0] f3Add = 3'b000;
    localparam logic [2:0] f3Sll = 3'b001;
    localparam logic [2:0] f3Slt = 3'b010;
    localparam logic [2:0] f3Sltu = 3'b011;
    localparam logic [2:0] f3Xor = 3'b100;
    localparam logic [2:0] f3Srl = 3'b101;
    localparam logic [2:0] f3Or = 3'b110;
    localparam logic [2:0] f3And = 3'b111;

    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;
    localparam logic [2:0] f3Blt = 3'b100;
    localparam logic [2:0] f3Bge = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    localparam logic [2:0] f3Word = 3'b010;

    // selects sub and sra
    localparam logic [6:0] funct7Alt = 7'b0100000;

    localparam logic [xlen-1:0] instrStep = 32'd4;
    localparam logic [3:0] storeAllLanes = 4'b1111;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassImm,
        aluAddPc,
        aluAddAddr
    } aluOp;

endpackage

`default_nettype wire
